// ==== Makefile ====
VERILATOR  = verilator
VFLAGS     = --binary --timing
LINT_FLAGS = --lint-only --timing
TOP        = la_tb
FILELIST   = verilog.f
OBJ_DIR    = obj_dir
LOG        = sim.log

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: build
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@grep -q "ALL CHECKS PASSED" $(LOG)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== source/la_capture.sv ====
`timescale 1ns/1ps

module la_capture (
   input  logic                           observer_clk,
   input  logic                           reset,
   input  logic                           capture_go,
   input  logic [la_pkg::probe_width-1:0] sample,
   input  logic [la_pkg::depth_width-1:0] depth,
   input  logic [la_pkg::ds_width-1:0]    downsample,
   output logic                           capturing,
   output logic                           capture_go_taken,
   output logic                           fifo_wr,
   output la_pkg::sample_word_t           fifo_wr_data,
   output logic                           capture_start,
   output logic                           capture_done
);

   logic [la_pkg::ds_width-1:0]    ds_count;
   logic [la_pkg::depth_width-1:0] sample_count;
   logic                           capturing_r;
   logic                           pair_odd; // Older half of a pair is held
   logic                           ds_tick;
   logic                           take;

   assign capture_go_taken = capture_go & ~capturing;
   assign ds_tick          = (ds_count == downsample);
   assign take             = capturing & ds_tick;

   // Downsample counter, restarted on every accepted start
   always_ff @(posedge observer_clk) begin
      if (reset) begin
         ds_count <= '0;
      end else if (capture_go_taken || ds_tick) begin
         ds_count <= '0;
      end else begin
         ds_count <= ds_count + 1'b1;
      end
   end

   always_ff @(posedge observer_clk) begin
      if (reset) begin
         capturing    <= 1'b0;
         capturing_r  <= 1'b0;
         pair_odd     <= 1'b0;
         fifo_wr      <= 1'b0;
         sample_count <= '0;
      end else begin
         capturing_r <= capturing;
         fifo_wr     <= 1'b0;
         if (capture_go_taken) begin
            capturing    <= 1'b1;
            pair_odd     <= 1'b0;
            sample_count <= '0;
         end else if (take) begin
            pair_odd     <= ~pair_odd;
            fifo_wr      <= pair_odd; // Second sample completes the word
            sample_count <= sample_count + 1'b1;
            if (sample_count == depth - 1'b1) begin
               capturing <= 1'b0;
            end
         end
      end
   end

   // Two-deep history per channel, shifted on each sample
   always_ff @(posedge observer_clk) begin
      if (take) begin
         for (int ch = 0; ch < la_pkg::probe_width; ch++) begin
            fifo_wr_data[ch] <= {fifo_wr_data[ch][0], sample[ch]};
         end
      end
   end

   assign capture_start = capturing & ~capturing_r;
   assign capture_done  = capturing_r & ~capturing;

endmodule

// ==== source/la_pkg.sv ====
package la_pkg;

   localparam int probe_width    = 9;
   localparam int trig_sel_width = 4;
   localparam int group_width    = 3;
   localparam int depth_width    = 32;
   localparam int ds_width       = 16;
   localparam int sync_stages    = 2;
   localparam int apb_addr_width = 8;
   localparam int apb_data_width = 32;

   // Register map
   localparam logic [apb_addr_width-1:0] addr_ctrl       = 8'h00;
   localparam logic [apb_addr_width-1:0] addr_trigger    = 8'h04;
   localparam logic [apb_addr_width-1:0] addr_group      = 8'h08;
   localparam logic [apb_addr_width-1:0] addr_depth      = 8'h0C;
   localparam logic [apb_addr_width-1:0] addr_downsample = 8'h10;
   localparam logic [apb_addr_width-1:0] addr_status     = 8'h14; // Read only

   localparam logic [group_width-1:0] group_io    = 3'd0;
   localparam logic [group_width-1:0] group_user  = 3'd1;
   localparam logic [group_width-1:0] group_debug = 3'd2;
   localparam logic [group_width-1:0] group_ramp  = 3'd3;

   localparam logic [probe_width-1:0] pattern_fixed = 9'h155; // Even channels high
   localparam logic [depth_width-1:0] depth_reset   = 32'd2;

   typedef struct packed {
      logic                      psel;
      logic                      penable;
      logic                      pwrite;
      logic [apb_addr_width-1:0] paddr;
      logic [apb_data_width-1:0] pwdata;
   } apb_req_t;

   typedef struct packed {
      logic [apb_data_width-1:0] prdata;
      logic                      pready;
      logic                      pslverr;
   } apb_rsp_t;

   typedef struct packed {
      logic [3:0] io;
      logic [1:0] hs;
      logic       aux;
      logic       trig;
      logic [7:0] user;
      logic       user_clk;
      logic [8:0] debug;
   } probe_in_t;

   typedef struct packed {
      logic [trig_sel_width-1:0] trig_sel;
      logic                      trig_invert;
      logic                      manual;     // Level ORed into the trigger source
      logic [group_width-1:0]    group;
      logic [depth_width-1:0]    depth;
      logic [ds_width-1:0]       downsample;
   } la_cfg_t;

   // Channel n in bits 2n+1:2n, older sample in the high bit
   typedef logic [probe_width-1:0][1:0] sample_word_t;

endpackage

// ==== source/la_probe_mux.sv ====
`timescale 1ns/1ps

module la_probe_mux (
   input  logic                           observer_clk,
   input  logic                           reset,
   input  la_pkg::probe_in_t              probes,
   input  logic [la_pkg::group_width-1:0] group,
   output logic [la_pkg::probe_width-1:0] sample
);

   logic [la_pkg::probe_width-1:0] ramp;
   logic [la_pkg::probe_width-1:0] sample_next;

   // Free-running test pattern
   always_ff @(posedge observer_clk) begin
      if (reset) begin
         ramp <= '0;
      end else begin
         ramp <= ramp + 1'b1;
      end
   end

   always_comb begin
      case (group)
         la_pkg::group_io:
            sample_next = {1'b0, probes.trig, probes.aux, probes.hs, probes.io};
         la_pkg::group_user:
            sample_next = {probes.user_clk, probes.user};
         la_pkg::group_debug:
            sample_next = probes.debug;
         la_pkg::group_ramp:
            sample_next = ramp;
         default:
            sample_next = la_pkg::pattern_fixed; // Unused codes
      endcase
   end

   // One cycle of latency into the capture engine
   always_ff @(posedge observer_clk) begin
      sample <= sample_next;
   end

endmodule

// ==== source/la_regs.sv ====
`timescale 1ns/1ps

module la_regs (
   input  logic              observer_clk,
   input  logic              reset,
   input  la_pkg::apb_req_t  apb,
   output la_pkg::apb_rsp_t  apb_rsp,
   input  logic              capturing,
   input  logic              capture_go_taken,
   output la_pkg::la_cfg_t   cfg,
   output logic              arm
);

   logic                              wr_en;
   logic                              addr_hit;
   logic                              status_wr;
   logic [la_pkg::apb_data_width-1:0] rd_data;

   assign wr_en     = apb.psel & apb.penable & apb.pwrite; // Zero wait states
   assign status_wr = apb.pwrite & (apb.paddr == la_pkg::addr_status);

   // Read mux and address decode
   always_comb begin
      addr_hit = 1'b1;
      rd_data  = '0;
      case (apb.paddr)
         la_pkg::addr_ctrl:       rd_data[1:0] = {cfg.manual, arm};
         la_pkg::addr_trigger:    rd_data[la_pkg::trig_sel_width:0] = {cfg.trig_invert, cfg.trig_sel};
         la_pkg::addr_group:      rd_data[la_pkg::group_width-1:0] = cfg.group;
         la_pkg::addr_depth:      rd_data = cfg.depth;
         la_pkg::addr_downsample: rd_data[la_pkg::ds_width-1:0] = cfg.downsample;
         la_pkg::addr_status:     rd_data[1:0] = {capturing, arm};
         default:                 addr_hit = 1'b0;
      endcase
   end

   assign apb_rsp.prdata  = (apb.psel && !apb.pwrite) ? rd_data : '0;
   assign apb_rsp.pready  = 1'b1;
   assign apb_rsp.pslverr = apb.psel & apb.penable & (~addr_hit | status_wr);

   always_ff @(posedge observer_clk) begin
      if (reset) begin
         cfg.trig_sel    <= '0;
         cfg.trig_invert <= 1'b0;
         cfg.manual      <= 1'b0;
         cfg.group       <= '0;
         cfg.depth       <= la_pkg::depth_reset;
         cfg.downsample  <= '0;
      end else if (wr_en) begin
         case (apb.paddr)
            la_pkg::addr_ctrl:
               cfg.manual <= apb.pwdata[1];
            la_pkg::addr_trigger: begin
               cfg.trig_sel    <= apb.pwdata[la_pkg::trig_sel_width-1:0];
               cfg.trig_invert <= apb.pwdata[la_pkg::trig_sel_width];
            end
            la_pkg::addr_group:
               cfg.group <= apb.pwdata[la_pkg::group_width-1:0];
            la_pkg::addr_depth:
               cfg.depth <= apb.pwdata[la_pkg::depth_width-1:0];
            la_pkg::addr_downsample:
               cfg.downsample <= apb.pwdata[la_pkg::ds_width-1:0];
            default: ;
         endcase
      end
   end

   // Arm is set by software, cleared by the capture engine on start
   always_ff @(posedge observer_clk) begin
      if (reset) begin
         arm <= 1'b0;
      end else if (wr_en && apb.paddr == la_pkg::addr_ctrl && apb.pwdata[0]) begin
         arm <= 1'b1;
      end else if (capture_go_taken) begin
         arm <= 1'b0;
      end
   end

endmodule

// ==== source/la_top.sv ====
`timescale 1ns/1ps

module la_top (
   input  logic                 observer_clk,
   input  logic                 reset,
   input  la_pkg::apb_req_t     apb,
   output la_pkg::apb_rsp_t     apb_rsp,
   input  la_pkg::probe_in_t    probes,
   output logic                 fifo_wr,
   output la_pkg::sample_word_t fifo_wr_data,
   output logic                 capture_start,
   output logic                 capture_done
);

   la_pkg::la_cfg_t                cfg;
   logic                           arm;
   logic                           capturing;
   logic                           capture_go;
   logic                           capture_go_taken;
   logic [la_pkg::probe_width-1:0] sample;

   la_regs u_regs (
      .observer_clk     (observer_clk),
      .reset            (reset),
      .apb              (apb),
      .apb_rsp          (apb_rsp),
      .capturing        (capturing),
      .capture_go_taken (capture_go_taken),
      .cfg              (cfg),
      .arm              (arm)
   );

   la_trigger u_trigger (
      .observer_clk (observer_clk),
      .reset        (reset),
      .probes       (probes),
      .cfg          (cfg),
      .arm          (arm),
      .capturing    (capturing),
      .capture_go   (capture_go)
   );

   la_probe_mux u_probe_mux (
      .observer_clk (observer_clk),
      .reset        (reset),
      .probes       (probes),
      .group        (cfg.group),
      .sample       (sample)
   );

   la_capture u_capture (
      .observer_clk     (observer_clk),
      .reset            (reset),
      .capture_go       (capture_go),
      .sample           (sample),
      .depth            (cfg.depth),
      .downsample       (cfg.downsample),
      .capturing        (capturing),
      .capture_go_taken (capture_go_taken),
      .fifo_wr          (fifo_wr),
      .fifo_wr_data     (fifo_wr_data),
      .capture_start    (capture_start),
      .capture_done     (capture_done)
   );

endmodule

// ==== source/la_trigger.sv ====
`timescale 1ns/1ps

module la_trigger (
   input  logic              observer_clk,
   input  logic              reset,
   input  la_pkg::probe_in_t probes,
   input  la_pkg::la_cfg_t   cfg,
   input  logic              arm,
   input  logic              capturing,
   output logic              capture_go
);

   logic [la_pkg::trig_sel_width-1:0] user_idx;
   logic                              pin;
   logic                              trig_src;
   logic [la_pkg::sync_stages-1:0]    sync;
   logic                              sync_prev; // Last stage, one cycle older

   assign user_idx = cfg.trig_sel - 4'd4;

   // Source select
   always_comb begin
      case (cfg.trig_sel)
         4'd0, 4'd1, 4'd2, 4'd3: pin = probes.io[cfg.trig_sel[1:0]];
         4'd12:                  pin = probes.hs[0];
         4'd13:                  pin = probes.hs[1];
         4'd14:                  pin = probes.aux;
         4'd15:                  pin = probes.trig;
         default:                pin = probes.user[user_idx[2:0]]; // Codes 4 to 11
      endcase
   end

   assign trig_src = (pin ^ cfg.trig_invert) | cfg.manual;

   always_ff @(posedge observer_clk) begin
      if (reset) begin
         sync       <= '0;
         sync_prev  <= 1'b0;
         capture_go <= 1'b0;
      end else begin
         sync      <= {sync[la_pkg::sync_stages-2:0], trig_src};
         sync_prev <= sync[la_pkg::sync_stages-1];
         // Rising edge only counts while armed and idle
         capture_go <= sync[la_pkg::sync_stages-1] & ~sync_prev & arm & ~capturing;
      end
   end

endmodule

// ==== test/la_tb.sv ====
`timescale 1ns/1ps

module la_tb;

   logic                 observer_clk;
   logic                 reset;
   la_pkg::apb_req_t     apb;
   la_pkg::apb_rsp_t     apb_rsp;
   la_pkg::probe_in_t    probes;
   logic                 fifo_wr;
   la_pkg::sample_word_t fifo_wr_data;
   logic                 capture_start;
   logic                 capture_done;

   int                   errors;
   int                   tests;
   int                   failed;
   int                   starts;
   int                   dones;
   int                   words;
   int                   cycle;
   int                   last_wr_cycle;
   int                   mode;      // 0 count only, 1 fixed word, 2 ramp spacing
   int                   ds_cfg;
   la_pkg::sample_word_t exp_word;

   la_top uut (
      .observer_clk  (observer_clk),
      .reset         (reset),
      .apb           (apb),
      .apb_rsp       (apb_rsp),
      .probes        (probes),
      .fifo_wr       (fifo_wr),
      .fifo_wr_data  (fifo_wr_data),
      .capture_start (capture_start),
      .capture_done  (capture_done)
   );

   always #5 observer_clk = ~observer_clk;

   // Output monitor sampled mid-cycle
   always @(negedge observer_clk) begin
      logic [8:0] old_s;
      logic [8:0] new_s;
      logic [8:0] diff;
      if (!reset) begin
         cycle = cycle + 1;
         if (capture_start) starts = starts + 1;
         if (capture_done) dones = dones + 1;
         if (fifo_wr) begin
            words = words + 1;
            if (mode == 1 && fifo_wr_data !== exp_word) begin
               $display("** Error t=%0t fifo_wr_data: got %h expected %h",
                        $time, fifo_wr_data, exp_word);
               errors = errors + 1;
            end
            if (mode == 2) begin
               for (int n = 0; n < la_pkg::probe_width; n++) begin
                  old_s[n] = fifo_wr_data[n][1];
                  new_s[n] = fifo_wr_data[n][0];
               end
               diff = new_s - old_s;
               if (diff != 9'(ds_cfg + 1)) begin
                  $display("** Error t=%0t ramp step: got %0d expected %0d",
                           $time, diff, ds_cfg + 1);
                  errors = errors + 1;
               end
               if (words > 1 && cycle - last_wr_cycle != 2 * (ds_cfg + 1)) begin
                  $display("** Error t=%0t fifo_wr spacing: got %0d expected %0d",
                           $time, cycle - last_wr_cycle, 2 * (ds_cfg + 1));
                  errors = errors + 1;
               end
            end
            last_wr_cycle = cycle;
         end
      end
   end

   task automatic check_value(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
      if (got !== exp) begin
         $display("** Error t=%0t %s: got %h expected %h", $time, name, got, exp);
         errors = errors + 1;
      end
   endtask

   task automatic apb_write(input logic [7:0] addr, input logic [31:0] data,
                            input logic exp_err);
      @(negedge observer_clk);
      apb.psel    = 1'b1;
      apb.penable = 1'b0;
      apb.pwrite  = 1'b1;
      apb.paddr   = addr;
      apb.pwdata  = data;
      @(negedge observer_clk);
      apb.penable = 1'b1;
      #1;
      check_value("pslverr", 32'(apb_rsp.pslverr), 32'(exp_err));
      check_value("pready", 32'(apb_rsp.pready), 32'h1);
      @(negedge observer_clk);
      apb.psel    = 1'b0;
      apb.penable = 1'b0;
      apb.pwrite  = 1'b0;
   endtask

   task automatic apb_read(input logic [7:0] addr, output logic [31:0] data,
                           input logic exp_err);
      @(negedge observer_clk);
      apb.psel    = 1'b1;
      apb.penable = 1'b0;
      apb.pwrite  = 1'b0;
      apb.paddr   = addr;
      @(negedge observer_clk);
      apb.penable = 1'b1;
      #1;
      check_value("pslverr", 32'(apb_rsp.pslverr), 32'(exp_err));
      check_value("pready", 32'(apb_rsp.pready), 32'h1);
      data = apb_rsp.prdata;
      @(negedge observer_clk);
      apb.psel    = 1'b0;
      apb.penable = 1'b0;
   endtask

   task automatic read_check(input logic [7:0] addr, input logic [31:0] exp,
                             input string name);
      logic [31:0] data;
      apb_read(addr, data, 1'b0);
      check_value(name, data, exp);
   endtask

   task automatic drive_trigger_pin(input logic [3:0] sel, input logic val);
      case (sel)
         4'd0, 4'd1, 4'd2, 4'd3: probes.io[sel[1:0]] = val;
         4'd12:                  probes.hs[0] = val;
         4'd13:                  probes.hs[1] = val;
         4'd14:                  probes.aux = val;
         4'd15:                  probes.trig = val;
         default:                probes.user[3'(sel - 4'd4)] = val;
      endcase
   endtask

   task automatic clear_counts;
      @(posedge observer_clk);
      starts = 0;
      dones  = 0;
      words  = 0;
   endtask

   task automatic wait_for_start(input int timeout);
      int n;
      n = 0;
      while (starts == 0 && n < timeout) begin
         @(posedge observer_clk);
         n++;
      end
      if (starts == 0) begin
         $display("Timeout while waiting for capture_start at t=%0t", $time);
         errors = errors + 1;
      end
   endtask

   task automatic wait_for_done(input int timeout);
      int n;
      n = 0;
      while (dones == 0 && n < timeout) begin
         @(posedge observer_clk);
         n++;
      end
      if (dones == 0) begin
         $display("Timeout while waiting for capture_done at t=%0t", $time);
         errors = errors + 1;
      end
   endtask

   task automatic report_test(input string name, input int err_before);
      tests++;
      if (errors == err_before) begin
         $display("test %s: ok", name);
      end else begin
         $display("test %s: %0d errors", name, errors - err_before);
         failed++;
      end
   endtask

   initial begin
      logic [31:0] rnd;
      logic [31:0] data;
      logic [3:0]  sel;
      logic        inv;
      logic [8:0]  s;
      int          depth;
      int          err0;

      void'($urandom(32'h5299d319));
      observer_clk = 1'b0;
      reset = 1'b1;
      apb = '0;
      probes = '0;
      errors = 0;
      tests = 0;
      failed = 0;
      starts = 0;
      dones = 0;
      words = 0;
      cycle = 0;
      last_wr_cycle = 0;
      mode = 0;
      ds_cfg = 0;
      exp_word = '0;
      repeat (16) @(posedge observer_clk);
      @(negedge observer_clk);
      reset = 1'b0;

      // Register access
      err0 = errors;
      read_check(la_pkg::addr_status, 32'h0, "status");
      rnd = $urandom();
      apb_write(la_pkg::addr_trigger, rnd, 1'b0);
      read_check(la_pkg::addr_trigger, rnd & 32'h1F, "trigger");
      rnd = $urandom();
      apb_write(la_pkg::addr_group, rnd, 1'b0);
      read_check(la_pkg::addr_group, rnd & 32'h7, "group");
      rnd = $urandom();
      apb_write(la_pkg::addr_depth, rnd, 1'b0);
      read_check(la_pkg::addr_depth, rnd, "depth");
      rnd = $urandom();
      apb_write(la_pkg::addr_downsample, rnd, 1'b0);
      read_check(la_pkg::addr_downsample, rnd & 32'hFFFF, "downsample");
      apb_read(8'h18, data, 1'b1);
      apb_write(la_pkg::addr_status, 32'h3, 1'b1);
      report_test("register access", err0);

      // Pin trigger with polarity
      err0 = errors;
      rnd = $urandom();
      sel = rnd[3:0];
      inv = rnd[4];
      probes = la_pkg::probe_in_t'(rnd[31:6]);
      drive_trigger_pin(sel, inv); // Inverted level low
      mode = 0;
      apb_write(la_pkg::addr_depth, 32'd2, 1'b0);
      apb_write(la_pkg::addr_downsample, 32'd0, 1'b0);
      apb_write(la_pkg::addr_group, 32'd0, 1'b0);
      apb_write(la_pkg::addr_trigger, {27'd0, inv, sel}, 1'b0);
      apb_write(la_pkg::addr_ctrl, 32'h1, 1'b0);
      read_check(la_pkg::addr_ctrl, 32'h1, "ctrl");
      clear_counts();
      @(negedge observer_clk);
      drive_trigger_pin(sel, ~inv);
      wait_for_start(20);
      wait_for_done(50);
      apb_read(la_pkg::addr_status, data, 1'b0);
      check_value("status.arm", 32'(data[0]), 32'h0);
      @(negedge observer_clk);
      drive_trigger_pin(sel, inv);
      repeat (5) @(negedge observer_clk);
      clear_counts();
      @(negedge observer_clk);
      drive_trigger_pin(sel, ~inv);
      repeat (20) @(posedge observer_clk);
      if (starts != 0) begin
         $display("Capture started without arm at t=%0t", $time);
         errors = errors + 1;
      end
      report_test("pin trigger", err0);

      // Capture content
      err0 = errors;
      rnd = $urandom();
      probes = la_pkg::probe_in_t'(rnd[25:0]);
      drive_trigger_pin(sel, inv); // Trigger source low before the manual edge
      rnd = $urandom();
      depth = 2 * (int'(rnd[2:0]) + 1);
      ds_cfg = int'(rnd[4:3]);
      case (rnd[6:5] % 2'd3)
         2'd0: begin
            s[3:0] = probes.io;
            s[5:4] = probes.hs;
            s[6]   = probes.aux;
            s[7]   = probes.trig;
            s[8]   = 1'b0;
         end
         2'd1: begin
            s[7:0] = probes.user;
            s[8]   = probes.user_clk;
         end
         default: begin
            s = probes.debug;
         end
      endcase
      for (int n = 0; n < la_pkg::probe_width; n++) begin
         exp_word[n] = {s[n], s[n]}; // Held probes
      end
      apb_write(la_pkg::addr_group, 32'(rnd[6:5] % 2'd3), 1'b0);
      apb_write(la_pkg::addr_depth, 32'(depth), 1'b0);
      apb_write(la_pkg::addr_downsample, 32'(ds_cfg), 1'b0);
      apb_write(la_pkg::addr_ctrl, 32'h0, 1'b0);
      mode = 1;
      clear_counts();
      apb_write(la_pkg::addr_ctrl, 32'h3, 1'b0);
      wait_for_done(200);
      if (dones != 0) check_value("fifo_wr count at done", 32'(words), 32'(depth / 2));
      read_check(la_pkg::addr_ctrl, 32'h2, "ctrl");
      apb_write(la_pkg::addr_ctrl, 32'h0, 1'b0);
      check_value("fifo_wr count", 32'(words), 32'(depth / 2));
      report_test("capture content", err0);

      // Downsample spacing
      err0 = errors;
      rnd = $urandom();
      ds_cfg = int'(rnd[2:0]);
      mode = 2;
      apb_write(la_pkg::addr_group, 32'(la_pkg::group_ramp), 1'b0);
      apb_write(la_pkg::addr_depth, 32'd8, 1'b0);
      apb_write(la_pkg::addr_downsample, 32'(ds_cfg), 1'b0);
      clear_counts();
      apb_write(la_pkg::addr_ctrl, 32'h3, 1'b0);
      wait_for_done(200);
      apb_write(la_pkg::addr_ctrl, 32'h0, 1'b0);
      check_value("fifo_wr count", 32'(words), 32'd4);
      report_test("downsample spacing", err0);

      // No restart while capturing, unused group code
      err0 = errors;
      rnd = $urandom();
      ds_cfg = 3;
      for (int n = 0; n < la_pkg::probe_width; n++) begin
         exp_word[n] = (n % 2 == 0) ? 2'b11 : 2'b00; // Even channels high
      end
      mode = 1;
      apb_write(la_pkg::addr_group, 32'(3'd4 + 3'(rnd[1:0])), 1'b0);
      apb_write(la_pkg::addr_downsample, 32'(ds_cfg), 1'b0);
      clear_counts();
      apb_write(la_pkg::addr_ctrl, 32'h3, 1'b0);
      wait_for_start(20);
      read_check(la_pkg::addr_status, 32'h2, "status");
      apb_write(la_pkg::addr_ctrl, 32'h0, 1'b0);
      apb_write(la_pkg::addr_ctrl, 32'h3, 1'b0); // Re-arm and new manual edge
      wait_for_done(200);
      repeat (10) @(posedge observer_clk);
      check_value("capture_start count", 32'(starts), 32'd1);
      check_value("fifo_wr count", 32'(words), 32'd4);
      report_test("no restart", err0);

      $display("tests %0d, failed %0d, errors %0d", tests, failed, errors);
      if (errors == 0) begin
         $display("ALL CHECKS PASSED");
      end else begin
         $display("CHECKS FAILED");
      end
      $finish;
   end

endmodule

// ==== verilog.f ====
source/la_pkg.sv
source/la_regs.sv
source/la_trigger.sv
source/la_probe_mux.sv
source/la_capture.sv
source/la_top.sv
test/la_tb.sv
